/* source/frv_defs.svh */
`ifndef FRV_DEFS_SVH
`define FRV_DEFS_SVH

// Datapath width of the integer slice
`define XLEN 32

// Width of the encoded pack width field
`define PW_BITS 3

// Pack width codes named after their lane size in bits
`define PW_32 3'd0 // One full-word lane
`define PW_16 3'd1 // Two halfword lanes
`define PW_8  3'd2 // Four byte lanes
`define PW_4  3'd3 // Eight nibble lanes
`define PW_2  3'd4 // Sixteen crumb lanes

// Codes 5 to 7 are unused
// They recode to all zeros and the datapath then runs as one 32-bit lane

`endif

/* source/frv_pkg.sv */
`default_nettype none

`include "frv_defs.svh"

package frv_pkg;

    // Encoded pack width as it arrives from decode
    typedef logic [`PW_BITS-1:0] pw_t;

    // One-hot lane size
    // Bit 0 is 32-bit lanes and bit 4 is 2-bit lanes
    typedef logic [4:0] pw_onehot_t;

    // Encoded to one-hot with zero for unused codes
    function automatic pw_onehot_t pw_recode(input pw_t pw);
        pw_onehot_t oh;
        oh = '0;
        case (pw)
            `PW_32:  oh[0] = 1'b1; // Full word
            `PW_16:  oh[1] = 1'b1; // Halves
            `PW_8:   oh[2] = 1'b1; // Bytes
            `PW_4:   oh[3] = 1'b1; // Nibbles
            `PW_2:   oh[4] = 1'b1; // Crumbs
            default: oh    = '0;   // Treated as 32-bit downstream
        endcase
        return oh;
    endfunction

endpackage

`default_nettype wire

/* source/p_addsub.sv */
`default_nettype none

`include "frv_defs.svh"

module p_addsub (
    input  wire logic [`XLEN-1:0]   lhs,    // Left operand
    input  wire logic [`XLEN-1:0]   rhs,    // Right operand
    input  frv_pkg::pw_onehot_t     pw,     // One-hot lane size
    input  wire logic               sub,    // Subtract when set
    output logic [`XLEN/2-1:0]      c_out,  // Carry out of each 2-bit group
    output logic [`XLEN-1:0]        result  // Lane-wise sum or difference
);

    // Number of 2-bit groups in the word
    localparam int NGRP = `XLEN / 2;

    logic [`XLEN-1:0] rhs_eff;    // rhs after optional inversion
    logic [NGRP-1:0]  lane_start; // Group begins a new lane
    logic             full_word;  // 32-bit lanes or unused code

    // Two's complement subtract is lhs + ~rhs + 1
    assign rhs_eff = sub ? ~rhs : rhs;

    // Zero one-hot falls back to a single lane
    assign full_word = pw[0] | ~|pw[4:1];

    // Which 2-bit groups sit on a lane boundary
    always_comb begin
        for (int i = 0; i < NGRP; i++) begin
            lane_start[i] = pw[4]                     | // Every group
                            (pw[3] & (i % 2 == 0))    | // Every 4 bits
                            (pw[2] & (i % 4 == 0))    | // Every 8 bits
                            (pw[1] & (i % 8 == 0))    | // Every 16 bits
                            (full_word & (i == 0));     // Bit 0 only
        end
    end

    // Group ripple cut at each lane start
    always_comb begin
        logic       carry;
        logic [2:0] grp_sum;
        carry = sub;
        for (int i = 0; i < NGRP; i++) begin
            if (lane_start[i]) begin
                carry = sub; // Lane carry-in is the +1 of subtract
            end
            grp_sum = {1'b0, lhs[2*i +: 2]} +
                      {1'b0, rhs_eff[2*i +: 2]} +
                      {2'b00, carry};
            result[2*i +: 2] = grp_sum[1:0];
            c_out[i]         = grp_sum[2];
            carry            = grp_sum[2]; // Into the next group
        end
    end

endmodule

`default_nettype wire

/* source/p_shfrot.sv */
`default_nettype none

`include "frv_defs.svh"

module p_shfrot (
    input  wire logic [`XLEN-1:0] crs1,   // Source operand
    input  wire logic [4:0]       shamt,  // Shift amount before lane reduction
    input  frv_pkg::pw_onehot_t   pw,     // One-hot lane size
    input  wire logic             shift,  // Shift op
    input  wire logic             rotate, // Rotate op
    input  wire logic             left,   // Left when set
    input  wire logic             arith,  // Sign fill on right shift
    output logic [`XLEN-1:0]      result  // Lane-wise result
);

    // One candidate word per lane size in one-hot order
    logic [`XLEN-1:0] size_res [5];

    logic             full_word; // 32-bit lanes or unused code

    for (genvar k = 0; k < 5; k++) begin : g_size
        localparam int LW = `XLEN >> k;  // Lane width
        localparam int NL = `XLEN / LW;  // Lanes in the word
        localparam int SW = 5 - k;       // log2 of lane width

        for (genvar j = 0; j < NL; j++) begin : g_lane
            logic [LW-1:0]   din;      // This lane of the operand
            logic [SW-1:0]   amt;      // shamt modulo lane width
            logic [2*LW-1:0] dbl_l;    // Doubled lane for rotate left
            logic [2*LW-1:0] dbl_r;    // Doubled lane for rotate right
            logic [LW-1:0]   fill;     // Sign bits for vacated positions
            logic [LW-1:0]   shf_res;
            logic [LW-1:0]   rot_res;
            logic [LW-1:0]   lane_out;

            assign din = crs1[j*LW +: LW];
            assign amt = shamt[SW-1:0]; // Low bits only

            // Rotate by shifting a doubled copy
            assign dbl_l   = {din, din} << amt;
            assign dbl_r   = {din, din} >> amt;
            assign rot_res = left ? dbl_l[2*LW-1 -: LW] : dbl_r[LW-1:0];

            // Ones above the logical shift result in negative lanes
            assign fill = {LW{arith & din[LW-1]}} & ~({LW{1'b1}} >> amt);

            assign shf_res = left ? (din << amt) : ((din >> amt) | fill);

            // Rotate has priority over shift
            assign lane_out = rotate ? rot_res : ({LW{shift}} & shf_res);

            assign size_res[k][j*LW +: LW] = lane_out;
        end
    end

    // Unused code lands here too
    assign full_word = pw[0] | ~|pw[4:1];

    // AND-OR select of the lane size
    assign result = ({`XLEN{full_word}} & size_res[0]) |
                    ({`XLEN{pw[1]}}     & size_res[1]) | // 16-bit
                    ({`XLEN{pw[2]}}     & size_res[2]) | // 8-bit
                    ({`XLEN{pw[3]}}     & size_res[3]) | // 4-bit
                    ({`XLEN{pw[4]}}     & size_res[4]);  // 2-bit

endmodule

`default_nettype wire

/* source/frv_alu.sv */
`default_nettype none

`include "frv_defs.svh"

module frv_alu (
    input  frv_pkg::pw_t          pw,             // Encoded pack width
    input  wire logic             op_add,         // Packed add
    input  wire logic             op_sub,         // Packed subtract
    input  wire logic             op_xor,         // Bitwise xor
    input  wire logic             op_or,          // Bitwise or
    input  wire logic             op_and,         // Bitwise and
    input  wire logic             op_shf,         // Packed shift
    input  wire logic             op_rot,         // Packed rotate
    input  wire logic             op_shf_left,    // Direction of shift/rotate
    input  wire logic             op_shf_arith,   // Sign fill on right shift
    input  wire logic             op_cmp,         // Set-less-than
    input  wire logic             op_unsigned,    // Unsigned compare
    input  wire logic [`XLEN-1:0] lhs,            // Left operand
    input  wire logic [`XLEN-1:0] rhs,            // Right operand
    output logic [`XLEN-1:0]      alu_result,     // Selected result
    output logic [`XLEN-1:0]      alu_add_result, // Adder output for every op
    output logic                  alu_lt,         // Whole-word less-than
    output logic                  alu_eq          // Whole-word equality
);

    frv_pkg::pw_onehot_t pw_oh;        // Lane size for both units

    logic [`XLEN-1:0]    adder_result;
    logic [`XLEN-1:0]    shift_result;
    logic [`XLEN-1:0]    bw_result;
    logic                lt_signed;
    logic                lt_unsigned;

    // Result steering
    logic                out_adder;
    logic                out_shift;
    logic                out_bw;

    assign pw_oh = frv_pkg::pw_recode(pw);

    // Lane-cut adder shared by add and sub
    p_addsub u_p_addsub (
        .lhs    (lhs),
        .rhs    (rhs),
        .pw     (pw_oh),
        .sub    (op_sub),
        .c_out  (),             // Group carries unused
        .result (adder_result)
    );

    assign alu_add_result = adder_result;

    // Whole-word flags for the branch unit
    assign lt_signed   = $signed(lhs) < $signed(rhs);
    assign lt_unsigned = lhs < rhs;
    assign alu_lt      = op_unsigned ? lt_unsigned : lt_signed;
    assign alu_eq      = (lhs == rhs);

    // Shift amount from the low rhs bits
    p_shfrot u_p_shfrot (
        .crs1   (lhs),
        .shamt  (rhs[4:0]),
        .pw     (pw_oh),
        .shift  (op_shf),
        .rotate (op_rot),
        .left   (op_shf_left),
        .arith  (op_shf_arith),
        .result (shift_result)
    );

    // Bitwise terms masked by their own op bits
    assign bw_result = ({`XLEN{op_xor}} & (lhs ^ rhs)) |
                       ({`XLEN{op_or}}  & (lhs | rhs)) |
                       ({`XLEN{op_and}} & (lhs & rhs));

    // Compare wins over an accompanying sub
    assign out_adder = (op_add | op_sub) & ~op_cmp;
    assign out_shift = op_shf | op_rot;
    assign out_bw    = op_xor | op_or | op_and;

    always_comb begin
        if (out_adder) begin
            alu_result = adder_result;
        end else begin
            alu_result = ({`XLEN{out_shift}} & shift_result) |
                         ({`XLEN{out_bw}}    & bw_result)    |
                         ({`XLEN{op_cmp}}    & {{(`XLEN-1){1'b0}}, alu_lt}); // Zero-extended
        end
    end

endmodule

`default_nettype wire

/* source/frv_execute.sv */
`default_nettype none

`include "frv_defs.svh"

module frv_execute (
    input  wire logic             g_clk,        // Core clock
    input  wire logic             rst_n,        // Sync reset, active low
    input  wire logic             in_valid,     // One-cycle op strobe
    input  wire logic             flush,        // Kill the op in this cycle
    input  frv_pkg::pw_t          pw,           // Encoded pack width
    input  wire logic             op_add,
    input  wire logic             op_sub,
    input  wire logic             op_xor,
    input  wire logic             op_or,
    input  wire logic             op_and,
    input  wire logic             op_shf,
    input  wire logic             op_rot,
    input  wire logic             op_shf_left,
    input  wire logic             op_shf_arith,
    input  wire logic             op_cmp,
    input  wire logic             op_unsigned,
    input  wire logic [`XLEN-1:0] lhs,          // Left operand
    input  wire logic [`XLEN-1:0] rhs,          // Right operand
    output logic                  out_valid,    // Result strobe one cycle later
    output logic [`XLEN-1:0]      result,       // Registered ALU result
    output logic [`XLEN-1:0]      add_result,   // Registered adder output
    output logic                  lt,           // Registered less-than
    output logic                  eq            // Registered equality
);

    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] alu_add_result;
    logic             alu_lt;
    logic             alu_eq;
    logic             accept;     // Op survives to the output stage

    frv_alu u_frv_alu (
        .pw             (pw),
        .op_add         (op_add),
        .op_sub         (op_sub),
        .op_xor         (op_xor),
        .op_or          (op_or),
        .op_and         (op_and),
        .op_shf         (op_shf),
        .op_rot         (op_rot),
        .op_shf_left    (op_shf_left),
        .op_shf_arith   (op_shf_arith),
        .op_cmp         (op_cmp),
        .op_unsigned    (op_unsigned),
        .lhs            (lhs),
        .rhs            (rhs),
        .alu_result     (alu_result),
        .alu_add_result (alu_add_result),
        .alu_lt         (alu_lt),
        .alu_eq         (alu_eq)
    );

    // Flush in the strobe cycle drops the op
    assign accept = in_valid & ~flush;

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            result     <= '0;
            add_result <= '0;
            lt         <= 1'b0;
            eq         <= 1'b0;
        end else begin
            out_valid <= accept; // High for exactly one cycle
            if (accept) begin
                // Outputs hold between ops
                result     <= alu_result;
                add_result <= alu_add_result;
                lt         <= alu_lt;
                eq         <= alu_eq;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/frv_alu_ref.svh */
`ifndef FRV_ALU_REF_SVH
`define FRV_ALU_REF_SVH

// Lane size in bits for an encoded pack width
function automatic int lane_width(input logic [`PW_BITS-1:0] pw_code);
    case (pw_code)
        `PW_16:  return 16;
        `PW_8:   return 8;
        `PW_4:   return 4;
        `PW_2:   return 2;
        default: return 32; // Full word and unused codes
    endcase
endfunction

// Low w bits set
function automatic logic [`XLEN-1:0] low_mask(input int w);
    return ~({`XLEN{1'b1}} << w); // Shift by 32 gives all ones
endfunction

// Lane-wise sum or difference wrapping inside each lane
function automatic logic [`XLEN-1:0] addsub_lanes(input logic [`XLEN-1:0] a,
                                                  input logic [`XLEN-1:0] b,
                                                  input logic [`PW_BITS-1:0] pw_code,
                                                  input logic sub);
    int               w;
    logic [`XLEN-1:0] mask;
    logic [`XLEN-1:0] la;
    logic [`XLEN-1:0] lb;
    logic [`XLEN-1:0] ls;
    logic [`XLEN-1:0] r;
    w    = lane_width(pw_code);
    mask = low_mask(w);
    r    = '0;
    for (int base = 0; base < `XLEN; base += w) begin
        la = (a >> base) & mask;
        lb = (b >> base) & mask;
        ls = sub ? (la - lb) : (la + lb); // Masked to the lane below
        r  = r | ((ls & mask) << base);
    end
    return r;
endfunction

// Lane-wise shift or rotate by the amount modulo the lane width
function automatic logic [`XLEN-1:0] shift_lanes(input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b,
                                                 input logic [`PW_BITS-1:0] pw_code,
                                                 input logic rotate,
                                                 input logic left,
                                                 input logic arith);
    int               w;
    int               amt;
    logic [`XLEN-1:0] mask;
    logic [`XLEN-1:0] la;
    logic [`XLEN-1:0] lr;
    logic [`XLEN-1:0] r;
    w    = lane_width(pw_code);
    mask = low_mask(w);
    amt  = int'(b[4:0]) % w;
    r    = '0;
    for (int base = 0; base < `XLEN; base += w) begin
        la = (a >> base) & mask;
        if (amt == 0) begin
            lr = la; // Nothing moves
        end else if (rotate) begin
            lr = left ? ((la << amt) | (la >> (w - amt))) :
                        ((la >> amt) | (la << (w - amt)));
        end else if (left) begin
            lr = la << amt;
        end else begin
            lr = la >> amt;
            if (arith && la[w-1]) begin
                lr = lr | (mask & ~(mask >> amt)); // Sign bits on top
            end
        end
        r = r | ((lr & mask) << base);
    end
    return r;
endfunction

// Whole-word less-than from the borrow of a wide subtract
// Signed order is unsigned order with both sign bits flipped
function automatic logic word_lt(input logic [`XLEN-1:0] a,
                                 input logic [`XLEN-1:0] b,
                                 input logic uns);
    logic [`XLEN-1:0] bias;
    logic [`XLEN:0]   diff;
    bias = uns ? '0 : {1'b1, {(`XLEN-1){1'b0}}};
    diff = {1'b0, a ^ bias} - {1'b0, b ^ bias};
    return diff[`XLEN]; // Borrow out
endfunction

// Adder result wins unless compare is set
function automatic logic [`XLEN-1:0] pick_result(input logic [`PW_BITS-1:0] pw_code,
                                                 input logic add,
                                                 input logic sub,
                                                 input logic bx,
                                                 input logic bo,
                                                 input logic ba,
                                                 input logic shf,
                                                 input logic rot,
                                                 input logic left,
                                                 input logic arith,
                                                 input logic cmp,
                                                 input logic uns,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
    logic [`XLEN-1:0] r;
    if ((add || sub) && !cmp) begin
        return addsub_lanes(a, b, pw_code, sub);
    end
    r = '0;
    if (shf || rot) r = r | shift_lanes(a, b, pw_code, rot, left, arith);
    if (bx)         r = r | (a ^ b);
    if (bo)         r = r | (a | b);
    if (ba)         r = r | (a & b);
    if (cmp)        r = r | {{(`XLEN-1){1'b0}}, word_lt(a, b, uns)}; // Zero-extended
    return r;
endfunction

`endif

/* bench/frv_execute_tb.sv */
`default_nettype none

`include "frv_defs.svh"

module frv_execute_tb;

    `include "frv_alu_ref.svh"

    logic             g_clk;
    logic             rst_n;
    logic             in_valid;
    logic             flush;
    frv_pkg::pw_t     pw;
    logic             op_add;
    logic             op_sub;
    logic             op_xor;
    logic             op_or;
    logic             op_and;
    logic             op_shf;
    logic             op_rot;
    logic             op_shf_left;
    logic             op_shf_arith;
    logic             op_cmp;
    logic             op_unsigned;
    logic [`XLEN-1:0] lhs;
    logic [`XLEN-1:0] rhs;
    logic             out_valid;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] add_result;
    logic             lt;
    logic             eq;

    // One expected entry per accepted op
    logic [`XLEN-1:0] exp_result_q[$];
    logic [`XLEN-1:0] exp_add_q[$];
    logic             exp_lt_q[$];
    logic             exp_eq_q[$];
    int               exp_cycle_q[$]; // Cycle in which out_valid is due

    // Last delivered values held while idle
    logic [`XLEN-1:0] held_result = '0;
    logic [`XLEN-1:0] held_add    = '0;
    logic             held_lt     = 1'b0;
    logic             held_eq     = 1'b0;

    logic [31:0]      rng_state = 32'd34905;
    int               cycle     = 0;
    int               errors    = 0;
    int               checks    = 0;
    int               timeouts  = 0;
    logic             checking  = 1'b0;

    frv_execute u_frv_execute (
        .g_clk        (g_clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .flush        (flush),
        .pw           (pw),
        .op_add       (op_add),
        .op_sub       (op_sub),
        .op_xor       (op_xor),
        .op_or        (op_or),
        .op_and       (op_and),
        .op_shf       (op_shf),
        .op_rot       (op_rot),
        .op_shf_left  (op_shf_left),
        .op_shf_arith (op_shf_arith),
        .op_cmp       (op_cmp),
        .op_unsigned  (op_unsigned),
        .lhs          (lhs),
        .rhs          (rhs),
        .out_valid    (out_valid),
        .result       (result),
        .add_result   (add_result),
        .lt           (lt),
        .eq           (eq)
    );

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    always @(posedge g_clk) cycle <= cycle + 1;

    // 32-bit xorshift
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Drive one op strobe
    // Kinds 0 to 7 are add, sub, xor, or, and, shift, rotate and compare
    task automatic issue(input frv_pkg::pw_t pw_v,
                         input int kind,
                         input logic [1:0] mode,
                         input logic [`XLEN-1:0] a,
                         input logic [`XLEN-1:0] b,
                         input logic kill);
        @(posedge g_clk);
        #1;
        in_valid     = 1'b1;
        flush        = kill;
        pw           = pw_v;
        lhs          = a;
        rhs          = b;
        op_add       = (kind == 0);
        op_sub       = (kind == 1) || (kind == 7 && mode[1]); // slt may carry sub
        op_xor       = (kind == 2);
        op_or        = (kind == 3);
        op_and       = (kind == 4);
        op_shf       = (kind == 5);
        op_rot       = (kind == 6);
        op_cmp       = (kind == 7);
        op_shf_left  = mode[0]; // Ignored by non-shift ops
        op_shf_arith = mode[1];
        op_unsigned  = mode[0];
        if (!kill) begin
            exp_result_q.push_back(pick_result(pw, op_add, op_sub, op_xor, op_or, op_and,
                                               op_shf, op_rot, op_shf_left, op_shf_arith,
                                               op_cmp, op_unsigned, lhs, rhs));
            exp_add_q.push_back(addsub_lanes(lhs, rhs, pw, op_sub));
            exp_lt_q.push_back(word_lt(lhs, rhs, op_unsigned));
            exp_eq_q.push_back(lhs == rhs);
            exp_cycle_q.push_back(cycle + 1);
        end
    endtask

    // Bubble cycle with optional flush
    task automatic idle(input logic kill);
        @(posedge g_clk);
        #1;
        in_valid = 1'b0;
        flush    = kill;
        lhs      = next_rand(); // Junk on the operands
        rhs      = next_rand();
    endtask

    // Hold rst_n low over three rising edges and look at the outputs
    task automatic reset_and_check();
        rst_n = 1'b0;
        repeat (3) @(posedge g_clk);
        #1;
        rst_n = 1'b1;
        @(negedge g_clk);
        assert (out_valid == 1'b0 && result == '0 && add_result == '0 && !lt && !eq)
        else begin
            errors++;
            $display("ERROR %0t: outputs not cleared by reset", $time);
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge g_clk) begin
        if (checking) begin
            if (out_valid) begin
                assert (exp_cycle_q.size() > 0) else begin
                    errors++;
                    $display("out_valid went high at time %0t with no accepted op waiting",
                             $time);
                end
                if (exp_cycle_q.size() > 0) begin
                    checks++;
                    held_result = exp_result_q.pop_front();
                    held_add    = exp_add_q.pop_front();
                    held_lt     = exp_lt_q.pop_front();
                    held_eq     = exp_eq_q.pop_front();
                    assert (exp_cycle_q[0] == cycle) else begin
                        errors++;
                        $display("ERROR %0t: out_valid in cycle %0d, due in cycle %0d",
                                 $time, cycle, exp_cycle_q[0]);
                    end
                    void'(exp_cycle_q.pop_front());
                    assert (result == held_result) else begin
                        errors++;
                        $display("ERROR %0t: result %h, expected %h",
                                 $time, result, held_result);
                    end
                    assert (add_result == held_add) else begin
                        errors++;
                        $display("ERROR %0t: add_result %h, expected %h",
                                 $time, add_result, held_add);
                    end
                    assert (lt == held_lt && eq == held_eq) else begin
                        errors++;
                        $display("ERROR %0t: lt/eq %b%b, expected %b%b",
                                 $time, lt, eq, held_lt, held_eq);
                    end
                end
            end else begin
                assert (result == held_result && add_result == held_add &&
                        lt == held_lt && eq == held_eq) else begin
                    errors++;
                    $display("ERROR %0t: outputs changed with out_valid low", $time);
                end
            end
        end
    end

    initial begin
        int               wait_cycles;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [31:0]      r;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        flush        = 1'b0;
        pw           = '0;
        lhs          = '0;
        rhs          = '0;
        op_add       = 1'b0;
        op_sub       = 1'b0;
        op_xor       = 1'b0;
        op_or        = 1'b0;
        op_and       = 1'b0;
        op_shf       = 1'b0;
        op_rot       = 1'b0;
        op_shf_left  = 1'b0;
        op_shf_arith = 1'b0;
        op_cmp       = 1'b0;
        op_unsigned  = 1'b0;
        reset_and_check();
        checking = 1'b1;
        repeat (3) idle(1'b0);

        // Every pack width with every op kind back to back
        for (int p = 0; p < 5; p++) begin
            for (int k = 0; k < 8; k++) begin
                for (int v = 0; v < 4; v++) begin
                    case (v)
                        0: begin // Equal pair
                            a = next_rand();
                            b = a;
                        end
                        1: begin // Sign edge
                            a = 32'h8000_0000;
                            b = 32'h7fff_ffff;
                        end
                        2: begin
                            a = 32'h7fff_ffff;
                            b = 32'h8000_0000;
                        end
                        default: begin
                            a = next_rand();
                            b = next_rand();
                        end
                    endcase
                    issue(3'(p), k, 2'(v), a, b, 1'b0);
                end
            end
        end

        // Flushed strobes and a quiet stretch
        issue(`PW_8, 0, 2'b00, next_rand(), next_rand(), 1'b1);
        issue(`PW_16, 5, 2'b10, next_rand(), next_rand(), 1'b1);
        issue(`PW_32, 1, 2'b00, next_rand(), next_rand(), 1'b0);
        repeat (4) idle(1'b1);
        repeat (4) idle(1'b0);

        // Random mix including unused pw codes
        for (int n = 0; n < 400; n++) begin
            r = next_rand();
            a = next_rand();
            b = (r[7:4] == 4'd0) ? a : next_rand();
            issue(3'(r % 8), int'(r[10:8]), r[12:11], a, b, r[15:13] == 3'd0);
            if (r[17:16] == 2'd0) idle(r[18]);
        end
        idle(1'b0);

        // Drain the expected queue
        wait_cycles = 0;
        while (exp_cycle_q.size() != 0 && wait_cycles < 20) begin
            @(posedge g_clk);
            wait_cycles++;
        end
        if (exp_cycle_q.size() != 0) begin
            timeouts++;
            $display("Timed out with %0d results never delivered", exp_cycle_q.size());
        end

        // Reset again over nonzero outputs
        issue(`PW_32, 3, 2'b00, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
        idle(1'b0);
        @(posedge g_clk);
        #1;
        checking = 1'b0; // Outputs drop to zero from here
        reset_and_check();

        $display("Checked %0d results, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+source
+incdir+bench
source/frv_pkg.sv
source/p_addsub.sv
source/p_shfrot.sv
source/frv_alu.sv
source/frv_execute.sv
bench/frv_execute_tb.sv

/* run.sh */
#!/bin/sh
# Build the bench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module frv_execute_tb &&
./obj_dir/Vfrv_execute_tb | tee /dev/stderr | grep -qx "Finished with no errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
